//--- hdl/id_pkg.sv
// Widths, field encodings and the instruction word layout shared by the decode stage
// Import into any module that touches decoded fields
`default_nettype none

package id_pkg;

    localparam int RF_ADDR_W = 5;  // Register file address
    localparam int PAYLOAD_W = 21; // Immediate payload
    localparam int F_W       = 4;  // {funct7[5], funct3}
    localparam int SCTRL_W   = 4;
    localparam int ICTRL_W   = 7;
    localparam int IMISCON_W = 3;

    // Source control bits
    localparam int SCTRL_RFRP1 = 0;
    localparam int SCTRL_RFRP2 = 1;
    localparam int SCTRL_ZERO1 = 2;
    localparam int SCTRL_ZERO2 = 3;

    // Unit select, one-hot
    localparam int ICTRL_ALU    = 0;
    localparam int ICTRL_LOAD   = 1;
    localparam int ICTRL_STORE  = 2;
    localparam int ICTRL_BRANCH = 3;
    localparam int ICTRL_JUMP   = 4;
    localparam int ICTRL_UPPER  = 5; // lui and auipc
    localparam int ICTRL_SYSTEM = 6;

    // Misconduct codes
    localparam logic [IMISCON_W-1:0] IMISCON_FREE      = 3'd0;
    localparam logic [IMISCON_W-1:0] IMISCON_ILLEGAL   = 3'd1;
    localparam logic [IMISCON_W-1:0] IMISCON_MISAL     = 3'd2;
    localparam logic [IMISCON_W-1:0] IMISCON_FETCH_ERR = 3'd3;

    // RV32I major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // Register file scrub address range
    localparam logic [RF_ADDR_W-1:0] SCRUB_FIRST = 5'd1;
    localparam logic [RF_ADDR_W-1:0] SCRUB_LAST  = 5'd31;

    // Same 32-bit word seen as R layout or as I layout
    typedef union packed {
        struct packed {
            logic [6:0]           funct7;
            logic [RF_ADDR_W-1:0] rs2;
            logic [RF_ADDR_W-1:0] rs1;
            logic [2:0]           funct3;
            logic [RF_ADDR_W-1:0] rd;
            logic [6:0]           opcode;
        } r;
        struct packed {
            logic [11:0]          imm;
            logic [RF_ADDR_W-1:0] rs1;
            logic [2:0]           funct3;
            logic [RF_ADDR_W-1:0] rd;
            logic [6:0]           opcode;
        } i;
    } instr_word_t;

endpackage

`default_nettype wire

//--- hdl/id_fetch_buffer.sv
// One-entry skid buffer between fetch and decode
// Catches the word fetch delivers while decode holds, then stalls fetch until it drains
`default_nettype none

module id_fetch_buffer (
    input  logic        s_clk_i,
    input  logic        arst_n_i,
    input  logic        s_flush_i,
    input  logic        s_hold_i,     // Decode cannot take a new word
    input  logic        s_fe_valid_i,
    input  logic [31:0] s_fe_instr_i,
    input  logic        s_fe_err_i,
    input  logic        s_fe_misal_i,
    output logic        s_stall_o,    // Fetch must keep its outputs
    output logic        s_valid_o,
    output logic [31:0] s_instr_o,
    output logic        s_err_o,
    output logic        s_misal_o
);

    logic        r_full;
    logic [31:0] r_instr;
    logic        r_err;
    logic        r_misal;
    logic        s_capture;

    assign s_stall_o = r_full;

    // Fetch word is only taken while fetch is not stalled
    assign s_capture = s_hold_i & s_fe_valid_i & ~s_stall_o & ~s_flush_i;

    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            r_full <= 1'b0;
        end else if (s_flush_i) begin
            r_full <= 1'b0;
        end else if (s_capture) begin
            r_full <= 1'b1;
        end else if (!s_hold_i) begin
            r_full <= 1'b0; // Stored word goes to decode this cycle
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (s_capture) begin
            r_instr <= s_fe_instr_i;
            r_err   <= s_fe_err_i;
            r_misal <= s_fe_misal_i;
        end
    end

    // Stored word has priority over the fetch bus
    always_comb begin
        if (r_full) begin
            s_valid_o = 1'b1;
            s_instr_o = r_instr;
            s_err_o   = r_err;
            s_misal_o = r_misal;
        end else begin
            s_valid_o = s_fe_valid_i;
            s_instr_o = s_fe_instr_i;
            s_err_o   = s_fe_err_i;
            s_misal_o = s_fe_misal_i;
        end
    end

    // A second word must never overwrite the held one
    a_no_overwrite: assert property (
        @(posedge s_clk_i) disable iff (!arst_n_i)
        r_full && s_hold_i && !s_flush_i |=> r_full && $stable(r_instr)
    );

endmodule

`default_nettype wire

//--- hdl/id_decoder.sv
// Combinational RV32I decoder
// Splits a fetched word into register addresses, immediate payload and control fields
`default_nettype none

module id_decoder import id_pkg::*; (
    input  logic                 s_valid_i,
    input  instr_word_t          s_instr_i,
    input  logic                 s_err_i,
    input  logic                 s_misal_i,
    output logic [RF_ADDR_W-1:0] s_rd_o,
    output logic [RF_ADDR_W-1:0] s_rs1_o,
    output logic [RF_ADDR_W-1:0] s_rs2_o,
    output logic [PAYLOAD_W-1:0] s_payload_o,
    output logic [F_W-1:0]       s_f_o,
    output logic [SCTRL_W-1:0]   s_sctrl_o,
    output logic [ICTRL_W-1:0]   s_ictrl_o,
    output logic [IMISCON_W-1:0] s_imiscon_o
);

    logic [PAYLOAD_W-1:0] s_imm_i, s_imm_s, s_imm_b, s_imm_j, s_imm_u;
    logic [PAYLOAD_W-1:0] s_payload;
    logic [F_W-1:0]       s_f;
    logic [ICTRL_W-1:0]   s_ictrl;
    logic                 s_legal, s_use_rs1, s_use_rs2, s_use_rd;
    logic                 s_f7_zero, s_f7_alt;
    logic [2:0]           s_funct3;

    assign s_funct3  = s_instr_i.r.funct3;
    assign s_f7_zero = s_instr_i.r.funct7 == 7'b0000000;
    assign s_f7_alt  = s_instr_i.r.funct7 == 7'b0100000; // sub, sra, srai

    // Immediates, sign extended and cut to the payload width
    assign s_imm_i = {{9{s_instr_i.i.imm[11]}}, s_instr_i.i.imm};
    assign s_imm_s = {{9{s_instr_i.r.funct7[6]}}, s_instr_i.r.funct7, s_instr_i.r.rd};
    assign s_imm_b = {{8{s_instr_i.r.funct7[6]}}, s_instr_i.r.funct7[6], s_instr_i.r.rd[0],
                      s_instr_i.r.funct7[5:0], s_instr_i.r.rd[4:1], 1'b0};
    assign s_imm_j = {s_instr_i.r.funct7[6], s_instr_i.r.rs1, s_funct3, s_instr_i.r.rs2[0],
                      s_instr_i.r.funct7[5:0], s_instr_i.r.rs2[4:1], 1'b0};
    assign s_imm_u = {1'b0, s_instr_i.r.funct7, s_instr_i.r.rs2, s_instr_i.r.rs1, s_funct3};

    always_comb begin
        s_legal   = 1'b1;
        s_ictrl   = '0;
        s_use_rs1 = 1'b0;
        s_use_rs2 = 1'b0;
        s_use_rd  = 1'b1;
        s_payload = '0;
        s_f       = {1'b0, s_funct3};
        case (s_instr_i.r.opcode)
            OPC_LUI: begin
                s_ictrl[ICTRL_UPPER] = 1'b1;
                s_payload            = s_imm_u;
                s_f                  = 4'b0000;
            end
            OPC_AUIPC: begin
                s_ictrl[ICTRL_UPPER] = 1'b1;
                s_payload            = s_imm_u;
                s_f                  = 4'b0001; // Adds pc
            end
            OPC_JAL: begin
                s_ictrl[ICTRL_JUMP] = 1'b1;
                s_payload           = s_imm_j;
                s_f                 = 4'b0000;
            end
            OPC_JALR: begin
                s_ictrl[ICTRL_JUMP] = 1'b1;
                s_use_rs1           = 1'b1;
                s_payload           = s_imm_i;
                s_legal             = s_funct3 == 3'b000;
            end
            OPC_BRANCH: begin
                s_ictrl[ICTRL_BRANCH] = 1'b1;
                s_use_rs1             = 1'b1;
                s_use_rs2             = 1'b1;
                s_use_rd              = 1'b0;
                s_payload             = s_imm_b;
                s_legal               = !(s_funct3 inside {3'b010, 3'b011});
            end
            OPC_LOAD: begin
                s_ictrl[ICTRL_LOAD] = 1'b1;
                s_use_rs1           = 1'b1;
                s_payload           = s_imm_i;
                s_legal             = !(s_funct3 inside {3'b011, 3'b110, 3'b111});
            end
            OPC_STORE: begin
                s_ictrl[ICTRL_STORE] = 1'b1;
                s_use_rs1            = 1'b1;
                s_use_rs2            = 1'b1;
                s_use_rd             = 1'b0;
                s_payload            = s_imm_s;
                s_legal              = !s_funct3[2] && (s_funct3 != 3'b011);
            end
            OPC_OPIMM: begin
                s_ictrl[ICTRL_ALU] = 1'b1;
                s_use_rs1          = 1'b1;
                s_payload          = s_imm_i;
                s_f = {(s_funct3 == 3'b101) & s_instr_i.r.funct7[5], s_funct3};
                if (s_funct3 == 3'b001) begin
                    s_legal = s_f7_zero;
                end else if (s_funct3 == 3'b101) begin
                    s_legal = s_f7_zero | s_f7_alt;
                end
            end
            OPC_OP: begin
                s_ictrl[ICTRL_ALU] = 1'b1;
                s_use_rs1          = 1'b1;
                s_use_rs2          = 1'b1;
                s_f                = {s_instr_i.r.funct7[5], s_funct3};
                s_legal = s_f7_zero | (s_f7_alt & (s_funct3 inside {3'b000, 3'b101}));
            end
            OPC_SYSTEM: begin
                // Only ecall (imm 0) and ebreak (imm 1)
                s_ictrl[ICTRL_SYSTEM] = 1'b1;
                s_payload             = s_imm_i;
                s_legal = (s_funct3 == 3'b000) && (s_instr_i.i.rs1 == '0) &&
                          (s_instr_i.i.rd == '0) && (s_instr_i.i.imm[11:1] == '0);
            end
            default: begin
                s_legal  = 1'b0;
                s_use_rd = 1'b0;
            end
        endcase
    end

    // Fetch error beats misalignment beats illegal encoding
    always_comb begin
        if (!s_valid_i) begin
            s_imiscon_o = IMISCON_FREE;
        end else if (s_err_i) begin
            s_imiscon_o = IMISCON_FETCH_ERR;
        end else if (s_misal_i) begin
            s_imiscon_o = IMISCON_MISAL;
        end else if (!s_legal) begin
            s_imiscon_o = IMISCON_ILLEGAL;
        end else begin
            s_imiscon_o = IMISCON_FREE;
        end
    end

    assign s_rd_o      = (s_valid_i && s_use_rd) ? s_instr_i.r.rd : '0;
    assign s_rs1_o     = (s_valid_i && s_use_rs1) ? s_instr_i.r.rs1 : '0;
    assign s_rs2_o     = (s_valid_i && s_use_rs2) ? s_instr_i.r.rs2 : '0;
    assign s_payload_o = s_valid_i ? s_payload : '0;
    assign s_f_o       = s_valid_i ? s_f : '0;
    assign s_ictrl_o   = (s_imiscon_o == IMISCON_FREE && s_valid_i) ? s_ictrl : '0;

    always_comb begin
        s_sctrl_o              = '0;
        s_sctrl_o[SCTRL_RFRP1] = s_valid_i & s_use_rs1;
        s_sctrl_o[SCTRL_RFRP2] = s_valid_i & s_use_rs2;
        s_sctrl_o[SCTRL_ZERO1] = s_valid_i & (s_rs1_o == '0);
        s_sctrl_o[SCTRL_ZERO2] = s_valid_i & (s_rs2_o == '0);
    end

endmodule

`default_nettype wire

//--- hdl/id_stage.sv
// Instruction decode stage top: fetch buffer, decoder and ID/OP stage register
// Free read ports carry a rotating register-file scrub address when scrubbing is on
`default_nettype none

module id_stage import id_pkg::*; (
    input  logic                 s_clk_i,
    input  logic                 arst_n_i,
    input  logic                 s_fe_valid_i,
    input  logic [31:0]          s_fe_instr_i,
    input  logic                 s_fe_err_i,
    input  logic                 s_fe_misal_i,
    input  logic                 s_stall_i,    // From later stages
    input  logic                 s_flush_i,
    input  logic                 s_scrub_en_i,
    output logic                 s_stall_o,    // To fetch
    output logic [RF_ADDR_W-1:0] s_idop_rd_o,
    output logic [RF_ADDR_W-1:0] s_idop_rs1_o,
    output logic [RF_ADDR_W-1:0] s_idop_rs2_o,
    output logic [PAYLOAD_W-1:0] s_idop_payload_o,
    output logic [F_W-1:0]       s_idop_f_o,
    output logic [SCTRL_W-1:0]   s_idop_sctrl_o,
    output logic [ICTRL_W-1:0]   s_idop_ictrl_o,
    output logic [IMISCON_W-1:0] s_idop_imiscon_o
);

    logic                 s_hold, s_empty, s_load, s_bubble;
    logic                 s_buf_valid, s_buf_err, s_buf_misal;
    logic [31:0]          s_buf_instr;
    logic [RF_ADDR_W-1:0] s_dec_rd, s_dec_rs1, s_dec_rs2;
    logic [PAYLOAD_W-1:0] s_dec_payload;
    logic [F_W-1:0]       s_dec_f;
    logic [SCTRL_W-1:0]   s_dec_sctrl;
    logic [ICTRL_W-1:0]   s_dec_ictrl;
    logic [IMISCON_W-1:0] s_dec_imiscon;
    logic                 s_free1, s_free2, s_scrub_adv;
    logic [RF_ADDR_W-1:0] s_new_rs1, s_new_rs2;
    logic [RF_ADDR_W-1:0] r_scrub;

    // Stage register carries nothing executable
    assign s_empty = (s_idop_ictrl_o == '0) && (s_idop_imiscon_o == IMISCON_FREE);
    assign s_hold  = s_stall_i & ~s_empty;

    id_fetch_buffer i_fetch_buffer (
        .s_clk_i      (s_clk_i),
        .arst_n_i     (arst_n_i),
        .s_flush_i    (s_flush_i),
        .s_hold_i     (s_hold),
        .s_fe_valid_i (s_fe_valid_i),
        .s_fe_instr_i (s_fe_instr_i),
        .s_fe_err_i   (s_fe_err_i),
        .s_fe_misal_i (s_fe_misal_i),
        .s_stall_o    (s_stall_o),
        .s_valid_o    (s_buf_valid),
        .s_instr_o    (s_buf_instr),
        .s_err_o      (s_buf_err),
        .s_misal_o    (s_buf_misal)
    );

    id_decoder i_decoder (
        .s_valid_i   (s_buf_valid),
        .s_instr_i   (s_buf_instr),
        .s_err_i     (s_buf_err),
        .s_misal_i   (s_buf_misal),
        .s_rd_o      (s_dec_rd),
        .s_rs1_o     (s_dec_rs1),
        .s_rs2_o     (s_dec_rs2),
        .s_payload_o (s_dec_payload),
        .s_f_o       (s_dec_f),
        .s_sctrl_o   (s_dec_sctrl),
        .s_ictrl_o   (s_dec_ictrl),
        .s_imiscon_o (s_dec_imiscon)
    );

    assign s_load   = s_flush_i | ~s_hold;        // Flush wins over stall
    assign s_bubble = s_flush_i | ~s_buf_valid;

    // A port is free when it does not read the register file
    assign s_free1 = s_bubble | s_dec_sctrl[SCTRL_ZERO1] | ~s_dec_sctrl[SCTRL_RFRP1];
    assign s_free2 = s_bubble | s_dec_sctrl[SCTRL_ZERO2] | ~s_dec_sctrl[SCTRL_RFRP2];

    assign s_new_rs1 = (s_free1 & s_scrub_en_i) ? r_scrub : (s_bubble ? '0 : s_dec_rs1);
    assign s_new_rs2 = (s_free2 & s_scrub_en_i) ? r_scrub : (s_bubble ? '0 : s_dec_rs2);

    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s_idop_rd_o      <= '0;
            s_idop_rs1_o     <= '0;
            s_idop_rs2_o     <= '0;
            s_idop_payload_o <= '0;
            s_idop_f_o       <= '0;
            s_idop_sctrl_o   <= '0;
            s_idop_ictrl_o   <= '0;
            s_idop_imiscon_o <= IMISCON_FREE;
        end else if (s_load) begin
            s_idop_rs1_o <= s_new_rs1;
            s_idop_rs2_o <= s_new_rs2;
            if (s_bubble) begin
                s_idop_rd_o      <= '0;
                s_idop_payload_o <= '0;
                s_idop_f_o       <= '0;
                s_idop_sctrl_o   <= '0;
                s_idop_ictrl_o   <= '0;
                s_idop_imiscon_o <= IMISCON_FREE;
            end else begin
                s_idop_rd_o      <= s_dec_rd;
                s_idop_payload_o <= s_dec_payload;
                s_idop_f_o       <= s_dec_f;
                s_idop_sctrl_o   <= s_dec_sctrl;
                s_idop_ictrl_o   <= s_dec_ictrl;
                s_idop_imiscon_o <= s_dec_imiscon;
            end
        end
    end

    // Scrub address moves on once it has been handed out
    assign s_scrub_adv = s_load & (s_bubble | (s_scrub_en_i & (s_free1 | s_free2)));

    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            r_scrub <= SCRUB_FIRST;
        end else if (s_scrub_adv) begin
            r_scrub <= (r_scrub == SCRUB_LAST) ? SCRUB_FIRST : r_scrub + 1'b1;
        end
    end

    // Decoder and stage register agree that a unit is selected only for clean instructions
    a_ictrl_onehot: assert property (
        @(posedge s_clk_i) disable iff (!arst_n_i)
        $onehot0(s_idop_ictrl_o) &&
        ((s_idop_ictrl_o == '0) || (s_idop_imiscon_o == IMISCON_FREE))
    );

endmodule

`default_nettype wire

//--- verif/tb_id_stage.sv
// Directed testbench for the decode stage top level
// Runs reset, decode, misconduct, stall, flush and scrub tests in sequence
`default_nettype none

module tb_id_stage import id_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 2000; // Whole run takes about 100 cycles

    logic                 s_clk = 1'b0;
    logic                 arst_n;
    logic                 fe_valid;
    logic [31:0]          fe_instr;
    logic                 fe_err;
    logic                 fe_misal;
    logic                 stall_in;
    logic                 flush;
    logic                 scrub_en;
    logic                 stall_out;
    logic [RF_ADDR_W-1:0] idop_rd, idop_rs1, idop_rs2;
    logic [PAYLOAD_W-1:0] idop_payload;
    logic [F_W-1:0]       idop_f;
    logic [SCTRL_W-1:0]   idop_sctrl;
    logic [ICTRL_W-1:0]   idop_ictrl;
    logic [IMISCON_W-1:0] idop_imiscon;

    integer               seed = 32'h5828_2011;
    int                   cycle_count = 0;
    logic [RF_ADDR_W-1:0] ra, rb, rc;

    // Stimulus and expected results for one stream of words
    logic                 valid_q[$];
    logic [31:0]          word_q[$];
    logic                 err_q[$];
    logic                 misal_q[$];
    logic [63:0]          exp_q[$];
    logic [63:0]          mask_q[$];

    id_stage i_id_stage (
        .s_clk_i          (s_clk),
        .arst_n_i         (arst_n),
        .s_fe_valid_i     (fe_valid),
        .s_fe_instr_i     (fe_instr),
        .s_fe_err_i       (fe_err),
        .s_fe_misal_i     (fe_misal),
        .s_stall_i        (stall_in),
        .s_flush_i        (flush),
        .s_scrub_en_i     (scrub_en),
        .s_stall_o        (stall_out),
        .s_idop_rd_o      (idop_rd),
        .s_idop_rs1_o     (idop_rs1),
        .s_idop_rs2_o     (idop_rs2),
        .s_idop_payload_o (idop_payload),
        .s_idop_f_o       (idop_f),
        .s_idop_sctrl_o   (idop_sctrl),
        .s_idop_ictrl_o   (idop_ictrl),
        .s_idop_imiscon_o (idop_imiscon)
    );

    always #2 s_clk = ~s_clk;

    always @(posedge s_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Errors found");
            $fatal(1, "Timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
        end
    end

    task automatic check(input string test, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("Mismatch in %s: expected %h, actual %h", test, exp, act);
            $display("Errors found");
            $fatal(1, "Check failed in %s", test);
        end
    endtask

    // Layout {pad, rd, rs1, rs2, payload, f, sctrl, ictrl, imiscon}
    function automatic logic [63:0] idop_fields();
        return {10'd0, idop_rd, idop_rs1, idop_rs2, idop_payload, idop_f, idop_sctrl,
                idop_ictrl, idop_imiscon};
    endfunction

    // Unused ports read as x0, ZERO bits follow the addresses
    function automatic logic [63:0] pack_fields(
        input logic [4:0] rd, input logic use1, input logic [4:0] rs1, input logic use2,
        input logic [4:0] rs2, input logic [20:0] payload, input logic [3:0] f,
        input logic [6:0] ictrl
    );
        logic [4:0] a1;
        logic [4:0] a2;
        logic [3:0] sctrl;
        a1 = use1 ? rs1 : 5'd0;
        a2 = use2 ? rs2 : 5'd0;
        sctrl = {a2 == 5'd0, a1 == 5'd0, use2, use1};
        return {10'd0, rd, a1, a2, payload, f, sctrl, ictrl, 3'd0};
    endfunction

    function automatic logic [ICTRL_W-1:0] unit_sel(input int idx);
        logic [ICTRL_W-1:0] sel;
        sel = '0;
        sel[idx] = 1'b1;
        return sel;
    endfunction

    function automatic logic [4:0] next_scrub(input logic [4:0] addr);
        return (addr == 5'd31) ? 5'd1 : addr + 5'd1;
    endfunction

    task automatic drive_word(input logic valid, input logic [31:0] word, input logic err,
                              input logic misal);
        fe_valid <= valid;
        fe_instr <= word;
        fe_err   <= err;
        fe_misal <= misal;
    endtask

    task automatic queue_word(input logic valid, input logic [31:0] word, input logic err,
                              input logic misal, input logic [63:0] exp,
                              input logic [63:0] mask);
        valid_q.push_back(valid);
        word_q.push_back(word);
        err_q.push_back(err);
        misal_q.push_back(misal);
        exp_q.push_back(exp);
        mask_q.push_back(mask);
    endtask

    // Called right after a rising edge, one word per cycle, each checked one cycle later
    task automatic stream_words(input string test);
        int n;
        n = word_q.size();
        drive_word(valid_q[0], word_q[0], err_q[0], misal_q[0]);
        for (int i = 0; i < n; i++) begin
            @(posedge s_clk);
            if (i + 1 < n) begin
                drive_word(valid_q[i + 1], word_q[i + 1], err_q[i + 1], misal_q[i + 1]);
            end else begin
                drive_word(1'b0, 32'd0, 1'b0, 1'b0);
            end
            @(negedge s_clk);
            check($sformatf("%s[%0d]", test, i), exp_q[i] & mask_q[i],
                  idop_fields() & mask_q[i]);
        end
        valid_q.delete();
        word_q.delete();
        err_q.delete();
        misal_q.delete();
        exp_q.delete();
        mask_q.delete();
    endtask

    task automatic apply_reset();
        @(posedge s_clk);
        arst_n <= 1'b0;
        repeat (8) @(posedge s_clk);
        arst_n <= 1'b1;
    endtask

    task automatic reset_test();
        apply_reset();
        @(negedge s_clk);
        check("reset_fields", 64'd0, idop_fields());
        check("reset_stall", 64'd0, 64'(stall_out));
    endtask

    task automatic decode_test();
        logic [11:0] imm;
        logic [12:0] boff;
        logic [20:0] joff;
        ra = 5'($random(seed));
        rb = 5'($random(seed));
        rc = 5'($random(seed));
        queue_word(1'b1, {7'b0000000, rb, ra, 3'b000, rc, OPC_OP}, 1'b0, 1'b0,
                   pack_fields(rc, 1, ra, 1, rb, 21'd0, 4'b0000, unit_sel(ICTRL_ALU)), '1);
        queue_word(1'b1, {7'b0100000, rb, ra, 3'b000, rc, OPC_OP}, 1'b0, 1'b0,
                   pack_fields(rc, 1, ra, 1, rb, 21'd0, 4'b1000, unit_sel(ICTRL_ALU)), '1);
        imm = 12'hFDB; // addi -37
        queue_word(1'b1, {imm, ra, 3'b000, rc, OPC_OPIMM}, 1'b0, 1'b0,
                   pack_fields(rc, 1, ra, 0, 5'd0, {{9{imm[11]}}, imm}, 4'b0000,
                               unit_sel(ICTRL_ALU)), '1);
        imm = 12'h104;
        queue_word(1'b1, {imm, ra, 3'b010, rc, OPC_LOAD}, 1'b0, 1'b0,
                   pack_fields(rc, 1, ra, 0, 5'd0, {{9{imm[11]}}, imm}, 4'b0010,
                               unit_sel(ICTRL_LOAD)), '1);
        imm = 12'h8A4;
        queue_word(1'b1, {imm[11:5], rb, ra, 3'b010, imm[4:0], OPC_STORE}, 1'b0, 1'b0,
                   pack_fields(5'd0, 1, ra, 1, rb, {{9{imm[11]}}, imm}, 4'b0010,
                               unit_sel(ICTRL_STORE)), '1);
        boff = 13'h1FF0; // Branch back 16 bytes
        queue_word(1'b1, {boff[12], boff[10:5], rb, ra, 3'b000, boff[4:1], boff[11],
                   OPC_BRANCH}, 1'b0, 1'b0,
                   pack_fields(5'd0, 1, ra, 1, rb, {{8{boff[12]}}, boff}, 4'b0000,
                               unit_sel(ICTRL_BRANCH)), '1);
        joff = 21'h00804;
        queue_word(1'b1, {joff[20], joff[10:1], joff[11], joff[19:12], rc, OPC_JAL}, 1'b0,
                   1'b0, pack_fields(rc, 0, 5'd0, 0, 5'd0, joff, 4'b0000,
                                     unit_sel(ICTRL_JUMP)), '1);
        queue_word(1'b1, {20'hABCDE, rc, OPC_LUI}, 1'b0, 1'b0,
                   pack_fields(rc, 0, 5'd0, 0, 5'd0, {1'b0, 20'hABCDE}, 4'b0000,
                               unit_sel(ICTRL_UPPER)), '1);
        @(posedge s_clk);
        stream_words("decode");
    endtask

    // Only ictrl and imiscon are compared here
    task automatic misconduct_test();
        logic [31:0] add_word;
        add_word = {7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3, OPC_OP};
        queue_word(1'b1, add_word, 1'b1, 1'b0, 64'(IMISCON_FETCH_ERR), 64'h3FF);
        queue_word(1'b1, add_word, 1'b0, 1'b1, 64'(IMISCON_MISAL), 64'h3FF);
        queue_word(1'b1, 32'h1234_567F, 1'b0, 1'b0, 64'(IMISCON_ILLEGAL), 64'h3FF);
        queue_word(1'b1, add_word, 1'b1, 1'b1, 64'(IMISCON_FETCH_ERR), 64'h3FF);
        @(posedge s_clk);
        stream_words("misconduct");
    endtask

    task automatic stall_test();
        logic [63:0] e1;
        logic [63:0] e2;
        logic [63:0] e3;
        e1 = pack_fields(5'd4, 1, 5'd3, 0, 5'd0, 21'h10, 4'b0000, unit_sel(ICTRL_ALU));
        e2 = pack_fields(5'd7, 1, 5'd5, 1, 5'd6, 21'd0, 4'b0000, unit_sel(ICTRL_ALU));
        e3 = pack_fields(5'd8, 0, 5'd0, 0, 5'd0, 21'h12345, 4'b0000, unit_sel(ICTRL_UPPER));
        @(posedge s_clk);
        drive_word(1'b1, {12'h010, 5'd3, 3'b000, 5'd4, OPC_OPIMM}, 1'b0, 1'b0);
        @(posedge s_clk);
        drive_word(1'b1, {7'b0000000, 5'd6, 5'd5, 3'b000, 5'd7, OPC_OP}, 1'b0, 1'b0);
        stall_in <= 1'b1;
        @(negedge s_clk);
        check("stall_first", e1, idop_fields());
        check("stall_out_low", 64'd0, 64'(stall_out));
        @(posedge s_clk); // Second word goes into the buffer
        drive_word(1'b1, {20'h12345, 5'd8, OPC_LUI}, 1'b0, 1'b0);
        repeat (2) begin
            @(negedge s_clk);
            check("stall_hold", e1, idop_fields());
            check("stall_out_high", 64'd1, 64'(stall_out));
            @(posedge s_clk);
        end
        stall_in <= 1'b0;
        @(negedge s_clk);
        check("stall_release", e1, idop_fields());
        @(posedge s_clk);
        @(negedge s_clk);
        check("stall_buffered", e2, idop_fields());
        check("stall_out_fall", 64'd0, 64'(stall_out));
        @(posedge s_clk);
        drive_word(1'b0, 32'd0, 1'b0, 1'b0);
        @(negedge s_clk);
        check("stall_next", e3, idop_fields());
        @(posedge s_clk);
        @(negedge s_clk);
        check("stall_bubble", 64'd0, idop_fields());
    endtask

    task automatic flush_test();
        logic [63:0] e1;
        logic [63:0] e3;
        e1 = pack_fields(5'd12, 1, 5'd11, 1, 5'd13, 21'd0, 4'b0000, unit_sel(ICTRL_ALU));
        e3 = pack_fields(5'd14, 1, 5'd15, 0, 5'd0, 21'h1FFFFF, 4'b0000, unit_sel(ICTRL_ALU));
        @(posedge s_clk);
        drive_word(1'b1, {7'b0000000, 5'd13, 5'd11, 3'b000, 5'd12, OPC_OP}, 1'b0, 1'b0);
        @(posedge s_clk);
        drive_word(1'b1, {12'h020, 5'd1, 3'b000, 5'd2, OPC_OPIMM}, 1'b0, 1'b0);
        stall_in <= 1'b1;
        @(posedge s_clk);
        drive_word(1'b1, {12'hFFF, 5'd15, 3'b000, 5'd14, OPC_OPIMM}, 1'b0, 1'b0);
        @(negedge s_clk);
        check("flush_full", 64'd1, 64'(stall_out));
        @(posedge s_clk);
        flush <= 1'b1;
        @(negedge s_clk);
        check("flush_hold", e1, idop_fields());
        @(posedge s_clk);
        flush    <= 1'b0;
        stall_in <= 1'b0;
        @(negedge s_clk);
        check("flush_bubble", 64'd0, idop_fields());
        check("flush_stall_out", 64'd0, 64'(stall_out));
        @(posedge s_clk);
        drive_word(1'b0, 32'd0, 1'b0, 1'b0);
        @(negedge s_clk);
        check("flush_next", e3, idop_fields());
    endtask

    // Starts from reset so the scrub address is known
    task automatic scrub_test();
        logic [4:0]  scrub;
        logic [4:0]  a1;
        logic [4:0]  a2;
        logic [31:0] word;
        logic        valid;
        logic        use1;
        logic        use2;
        @(posedge s_clk);
        scrub_en <= 1'b1;
        drive_word(1'b0, 32'd0, 1'b0, 1'b0);
        apply_reset();
        ra = 5'($random(seed)) | 5'd1;
        rb = 5'($random(seed)) | 5'd1;
        scrub = 5'd1;
        for (int i = 0; i < 40; i++) begin
            valid = (i < 3);
            use1  = (i == 1) || (i == 2);
            use2  = (i == 1);
            if (i == 0) begin
                word = {20'h5A5A5, 5'd9, OPC_LUI};
            end else if (i == 1) begin
                word = {7'b0000000, rb, ra, 3'b000, 5'd10, OPC_OP};
            end else if (i == 2) begin
                word = {12'h7FF, ra, 3'b000, 5'd11, OPC_OPIMM};
            end else begin
                word = 32'd0;
            end
            a1 = (valid && use1) ? ra : scrub;
            a2 = (valid && use2) ? rb : scrub;
            queue_word(valid, word, 1'b0, 1'b0, (64'(a1) << 44) | (64'(a2) << 39),
                       64'h3FF << 39);
            if (!valid || !use1 || !use2) begin
                scrub = next_scrub(scrub); // A free port took the address
            end
        end
        stream_words("scrub");
    endtask

    initial begin
        arst_n   = 1'b0;
        fe_valid = 1'b0;
        fe_instr = 32'd0;
        fe_err   = 1'b0;
        fe_misal = 1'b0;
        stall_in = 1'b0;
        flush    = 1'b0;
        scrub_en = 1'b0;
        reset_test();
        decode_test();
        misconduct_test();
        stall_test();
        flush_test();
        scrub_test();
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
hdl/id_pkg.sv
hdl/id_fetch_buffer.sv
hdl/id_decoder.sv
hdl/id_stage.sv
verif/tb_id_stage.sv

//--- run.sh
#!/bin/sh
# Build the decode stage testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
    -f src.f --top-module tb_id_stage &&
./obj_dir/Vtb_id_stage || exit 1
